//--- list.f
+incdir+rtl
rtl/mem_unit_pkg.sv
rtl/load_store_queue.sv
rtl/mem_issue_ctrl.sv
rtl/mem_resp_stage.sv
rtl/mem_unit.sv
tb/tb_mem_unit.sv

//--- rtl/load_store_queue.sv
// In-order queue of memory instructions, one push and one pop per cycle
// Flush empties it on the next edge, stored entries are left as they are
`timescale 1ns/1ns
`include "mem_unit_macros.svh"

module load_store_queue
    import mem_unit_pkg::*;
(
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       flush_i,
    input  mem_instr_t instr_i,
    output logic       in_ready_o,
    input  logic       pop_i,
    output mem_instr_t head_o,
    output logic       head_valid_o
);

    localparam int PTR_W = $clog2(`MU_LSQ_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `MU_LSQ_DEPTH;

    mem_instr_t       entries_q [`MU_LSQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign in_ready_o   = (count_q != DEPTH);
    assign head_valid_o = (count_q != '0);
    assign push = instr_i.valid & in_ready_o;
    assign pop  = pop_i & head_valid_o;

    assign head_o = entries_q[rd_ptr_q];

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // Both or none
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) entries_q[wr_ptr_q] <= instr_i;
    end

    // Pointers agree with the count, so a push never lands on the live head
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        push |-> (count_q == '0) || (wr_ptr_q != rd_ptr_q));

    // Issue controller only pops a non-empty queue
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> head_valid_o);

endmodule

//--- rtl/mem_issue_ctrl.sv
// Sends one instruction per cycle to the dcache, stores only under commit
// At most one store in flight, its gl index is reported until it completes
`timescale 1ns/1ns
`include "mem_unit_macros.svh"

module mem_issue_ctrl
    import mem_unit_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   kill_i,
    input  mem_instr_t             head_i,
    input  logic                   head_valid_i,
    output logic                   pop_o,
    input  logic                   commit_store_i,
    input  logic                   dcache_ready_i,
    input  logic                   store_done_i,
    output dcache_req_t            req_o,
    output mem_instr_t             issue_o,
    output logic                   commit_stall_o,
    output logic [`MU_GL_BITS-1:0] mem_gl_index_o,
    output logic                   empty_o
);

    typedef enum logic [1:0] {
        READ_HEAD,
        WAIT_READY,
        WAIT_COMMIT
    } issue_state_e;

    issue_state_e state_q;
    issue_state_e state_d;
    mem_instr_t   held_q;
    logic         held_valid_q;
    logic         store_in_flight_q;
    mem_instr_t   cur;
    logic         cur_valid;
    logic         cur_store;
    logic         store_busy;
    logic         can_issue;
    logic         take_hold;

    ////////////////////////////////////////////////////////////
    // Candidate instruction and request
    ////////////////////////////////////////////////////////////

    assign cur       = (state_q == READ_HEAD) ? head_i : held_q;
    assign cur_valid = (state_q == READ_HEAD) ? head_valid_i : held_valid_q;
    assign cur_store = is_store(cur.op);

    // A store finishing this cycle frees the slot for the next one
    assign store_busy = store_in_flight_q & ~store_done_i;
    assign can_issue  = cur_valid & dcache_ready_i &
                        (~cur_store | (commit_store_i & ~store_busy));

    assign req_o.valid = can_issue & ~kill_i;
    assign req_o.op    = cur.op;
    assign req_o.base  = cur.base;
    assign req_o.imm   = cur.imm;
    assign req_o.data  = cur.data;
    assign req_o.kill  = kill_i;

    always_comb begin
        issue_o       = cur;
        issue_o.valid = req_o.valid;
    end

    // Head always leaves the queue, either to the cache or to the hold register
    assign pop_o     = (state_q == READ_HEAD) & head_valid_i;
    assign take_hold = pop_o & ~req_o.valid;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            READ_HEAD: begin
                // Ready but not sent means a store blocked by commit
                if (take_hold) state_d = dcache_ready_i ? WAIT_COMMIT : WAIT_READY;
            end
            WAIT_READY: begin
                if (req_o.valid) state_d = READ_HEAD;
                else if (dcache_ready_i) state_d = WAIT_COMMIT;
            end
            WAIT_COMMIT: begin
                if (req_o.valid) state_d = READ_HEAD;
            end
            default: state_d = READ_HEAD;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= READ_HEAD;
            held_valid_q <= 1'b0;
        end else if (kill_i) begin
            state_q      <= READ_HEAD;
            held_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_hold) begin
                held_valid_q <= 1'b1;
            end else if (req_o.valid && state_q != READ_HEAD) begin
                held_valid_q <= 1'b0;       // Held entry went out
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_hold) held_q <= head_i;
    end

    ////////////////////////////////////////////////////////////
    // Store in flight
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            store_in_flight_q <= 1'b0;
            mem_gl_index_o    <= '0;
        end else if (kill_i) begin
            store_in_flight_q <= 1'b0;
        end else if (req_o.valid && cur_store) begin
            store_in_flight_q <= 1'b1;
            mem_gl_index_o    <= cur.gl_index;
        end else if (store_done_i) begin
            store_in_flight_q <= 1'b0;
        end
    end

    assign commit_stall_o = (cur_valid & cur_store & commit_store_i & ~store_busy) | store_busy;
    assign empty_o = ~head_valid_i & ~held_valid_q & ~req_o.valid;

    // Hold register is in use exactly while the FSM waits
    a_hold_in_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
        held_valid_q == (state_q != READ_HEAD));

    // Held instruction is kept unchanged until it is sent
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        held_valid_q && !req_o.valid && !kill_i |=> held_valid_q && $stable(held_q));

endmodule

//--- rtl/mem_resp_stage.sv
// Tracks issued instructions for two cycles to meet the dcache response
// Assumes the cache answers exactly two cycles after accept and drops killed ones
`timescale 1ns/1ns
`include "mem_unit_macros.svh"

module mem_resp_stage
    import mem_unit_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         kill_i,
    input  mem_instr_t   issue_i,
    input  dcache_resp_t resp_i,
    output wb_t          wb_o,
    output exception_t   xcpt_commit_o,
    output logic         store_done_o
);

    mem_instr_t s1_q;
    mem_instr_t s2_q;
    logic       s1_valid_q;
    logic       s2_valid_q;
    logic       s2_store;
    logic       addr_noncanon;
    exception_t ex_s2;

    ////////////////////////////////////////////////////////////
    // Tracking pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (kill_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issue_i.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_q <= issue_i;
        s2_q <= s1_q;
    end

    assign s2_store = is_store(s2_q.op);

    ////////////////////////////////////////////////////////////
    // Exception decode at stage 2
    ////////////////////////////////////////////////////////////

    // Bits above the VA sign bit must all copy it
    assign addr_noncanon = resp_i.addr.va.sign ? ~&resp_i.addr.va.hi
                                               : |resp_i.addr.va.hi;

    always_comb begin
        ex_s2 = '0;
        if (s2_valid_q) begin
            if (s2_q.ex.valid) begin
                ex_s2 = s2_q.ex;                  // Inherited wins
            end else if (resp_i.valid) begin
                ex_s2.origin = resp_i.addr.raw;
                if (resp_i.misaligned) begin
                    ex_s2.valid = 1'b1;
                    ex_s2.cause = s2_store ? `MU_CAUSE_ST_MISALIGNED
                                           : `MU_CAUSE_LD_MISALIGNED;
                end else if (resp_i.page_fault) begin
                    ex_s2.valid = 1'b1;
                    ex_s2.cause = s2_store ? `MU_CAUSE_ST_PAGE_FAULT
                                           : `MU_CAUSE_LD_PAGE_FAULT;
                end else if (addr_noncanon) begin
                    ex_s2.valid = 1'b1;
                    ex_s2.cause = s2_store ? `MU_CAUSE_ST_ACCESS_FAULT
                                           : `MU_CAUSE_LD_ACCESS_FAULT;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    // Loads write back even when faulting, commit reads ex
    always_comb begin
        wb_o.valid    = s2_valid_q & ~s2_store;
        wb_o.rd       = s2_q.rd;
        wb_o.gl_index = s2_q.gl_index;
        wb_o.result   = resp_i.data;
        wb_o.ex       = ex_s2;
    end

    assign xcpt_commit_o = (s2_valid_q & s2_store & ex_s2.valid) ? ex_s2 : '0;
    assign store_done_o  = s2_valid_q & s2_store;    // Frees the in-flight slot

    // Every cache response lines up with a tracked instruction
    a_resp_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_i.valid |-> s2_valid_q);

endmodule

//--- rtl/mem_unit.sv
// Memory unit between register read and the dcache
// Kill from commit clears queue, hold register and pipeline on the next edge
`timescale 1ns/1ns
`include "mem_unit_macros.svh"

module mem_unit
    import mem_unit_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   kill_i,
    input  mem_instr_t             instr_i,
    output logic                   in_ready_o,
    input  logic                   commit_store_i,
    input  logic                   dcache_ready_i,
    input  dcache_resp_t           resp_i,
    output dcache_req_t            req_o,
    output wb_t                    wb_o,
    output exception_t             xcpt_commit_o,
    output logic                   commit_stall_o,
    output logic [`MU_GL_BITS-1:0] mem_gl_index_o,
    output logic                   empty_o
);

    mem_instr_t head;
    mem_instr_t issue;
    logic       head_valid;
    logic       pop;
    logic       store_done;

    load_store_queue u_lsq (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (kill_i),
        .instr_i      (instr_i),
        .in_ready_o   (in_ready_o),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid)
    );

    mem_issue_ctrl u_issue (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .kill_i         (kill_i),
        .head_i         (head),
        .head_valid_i   (head_valid),
        .pop_o          (pop),
        .commit_store_i (commit_store_i),
        .dcache_ready_i (dcache_ready_i),
        .store_done_i   (store_done),
        .req_o          (req_o),
        .issue_o        (issue),
        .commit_stall_o (commit_stall_o),
        .mem_gl_index_o (mem_gl_index_o),
        .empty_o        (empty_o)
    );

    mem_resp_stage u_resp (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .kill_i        (kill_i),
        .issue_i       (issue),
        .resp_i        (resp_i),
        .wb_o          (wb_o),
        .xcpt_commit_o (xcpt_commit_o),
        .store_done_o  (store_done)
    );

endmodule

//--- rtl/mem_unit_macros.svh
// Sizes and cause codes for the memory unit
// Queue depth must be a power of two, cause codes follow the RISC-V numbering
`ifndef MEM_UNIT_MACROS_SVH
`define MEM_UNIT_MACROS_SVH

// Geometry
`define MU_LSQ_DEPTH 8
`define MU_XLEN 64
`define MU_VA_BITS 40
`define MU_GL_BITS 6
`define MU_REG_BITS 5
`define MU_CAUSE_BITS 6

// Exception causes
`define MU_CAUSE_LD_MISALIGNED 6'd4
`define MU_CAUSE_LD_ACCESS_FAULT 6'd5
`define MU_CAUSE_ST_MISALIGNED 6'd6
`define MU_CAUSE_ST_ACCESS_FAULT 6'd7
`define MU_CAUSE_LD_PAGE_FAULT 6'd13
`define MU_CAUSE_ST_PAGE_FAULT 6'd15

`endif

//--- rtl/mem_unit_pkg.sv
// Types shared by the memory unit and its testbench
// Only integer loads and stores exist here, no AMO or FP forms
`include "mem_unit_macros.svh"

package mem_unit_pkg;

    // Loads first, stores after
    typedef enum logic [3:0] {
        LD, LW, LWU, LH, LHU, LB, LBU,
        SD, SW, SH, SB
    } mem_op_e;

    typedef struct packed {
        logic                      valid;
        logic [`MU_CAUSE_BITS-1:0] cause;
        logic [`MU_XLEN-1:0]       origin;  // Faulting address
    } exception_t;

    typedef struct packed {
        logic                    valid;
        mem_op_e                 op;
        logic [`MU_XLEN-1:0]     base;      // rs1 value
        logic [`MU_XLEN-1:0]     imm;
        logic [`MU_XLEN-1:0]     data;      // rs2 value, stores only
        logic [`MU_REG_BITS-1:0] rd;
        logic [`MU_GL_BITS-1:0]  gl_index;
        exception_t              ex;        // Raised by earlier stages
    } mem_instr_t;

    // Address seen either as a word or split around the VA sign bit
    typedef union packed {
        logic [`MU_XLEN-1:0] raw;
        struct packed {
            logic [`MU_XLEN-`MU_VA_BITS-1:0] hi;
            logic                            sign;
            logic [`MU_VA_BITS-2:0]          lo;
        } va;
    } mem_addr_u;

    typedef struct packed {
        logic                valid;
        mem_op_e             op;
        logic [`MU_XLEN-1:0] base;
        logic [`MU_XLEN-1:0] imm;
        logic [`MU_XLEN-1:0] data;
        logic                kill;
    } dcache_req_t;

    typedef struct packed {
        logic                valid;
        logic [`MU_XLEN-1:0] data;
        logic                misaligned;
        logic                page_fault;
        mem_addr_u           addr;      // base + imm as computed by the cache
    } dcache_resp_t;

    typedef struct packed {
        logic                    valid;
        logic [`MU_REG_BITS-1:0] rd;
        logic [`MU_GL_BITS-1:0]  gl_index;
        logic [`MU_XLEN-1:0]     result;
        exception_t              ex;
    } wb_t;

    function automatic logic is_store(input mem_op_e op);
        return (op == SD) || (op == SW) || (op == SH) || (op == SB);
    endfunction

endpackage

//--- tb/tb_mem_unit.sv
// Table-driven testbench with a dcache model that answers two cycles after accept
// Fault page is 0x3xxx, response data is a fixed function of the address
`timescale 1ns/1ns
`include "mem_unit_macros.svh"

module tb_mem_unit
    import mem_unit_pkg::*;
();

    localparam int N_ROWS = 14;
    localparam int LIMIT  = 40 * (2 * N_ROWS + `MU_LSQ_DEPTH + 1) + 16;

    typedef struct packed {
        mem_op_e                 op;
        logic [`MU_XLEN-1:0]     base;
        logic [`MU_XLEN-1:0]     imm;
        logic [`MU_REG_BITS-1:0] rd;
        logic [`MU_GL_BITS-1:0]  gl;
        logic                    inject;    // Inherited exception
        logic [`MU_XLEN-1:0]     data;      // Store data
    } row_t;

    logic         clk_i;
    logic         rstn_i;
    logic         kill_i;
    mem_instr_t   instr_i;
    logic         in_ready_o;
    logic         commit_store_i;
    logic         dcache_ready_i;
    dcache_resp_t resp_i;
    dcache_req_t  req_o;
    wb_t          wb_o;
    exception_t   xcpt_commit_o;
    logic         commit_stall_o;
    logic [`MU_GL_BITS-1:0] mem_gl_index_o;
    logic         empty_o;

    row_t        rows [N_ROWS];
    dcache_req_t exp_req [$];
    logic [`MU_GL_BITS-1:0] exp_gl [$];
    wb_t         exp_wb [$];
    exception_t  exp_xcpt [$];
    dcache_req_t p1;
    dcache_req_t p2;
    int          err_cnt;
    int          other_cnt;
    int          cyc;
    int          st_age;
    logic [`MU_GL_BITS-1:0] st_gl;
    logic        ready_low;
    int          pushed;
    int unsigned seed_dummy;
    mem_addr_u   nc_addr;

    mem_unit UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////

    function automatic int size_of(input mem_op_e op);
        case (op)
            LD, SD:       return 8;
            LW, LWU, SW:  return 4;
            LH, LHU, SH:  return 2;
            default:      return 1;
        endcase
    endfunction

    function automatic logic op_is_store(input mem_op_e op);
        case (op)
            SD, SW, SH, SB: return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    function automatic logic [`MU_XLEN-1:0] resp_data(input logic [`MU_XLEN-1:0] addr);
        return addr ^ 64'ha5a5_5a5a_0f0f_f0f0;
    endfunction

    function automatic logic is_misaligned(input mem_op_e op, input logic [63:0] addr);
        return (addr & (size_of(op) - 1)) != 0;
    endfunction

    function automatic logic on_fault_page(input logic [63:0] addr);
        return addr[63:12] == 52'h3;
    endfunction

    function automatic exception_t expect_ex(input row_t r);
        exception_t e;
        mem_addr_u  a;
        logic       st;
        a.raw = r.base + r.imm;
        st = op_is_store(r.op);
        e = '0;
        e.origin = a.raw;
        if (r.inject) begin
            e.valid = 1'b1;
            e.cause = `MU_CAUSE_LD_ACCESS_FAULT;
        end else if (is_misaligned(r.op, a.raw)) begin
            e.valid = 1'b1;
            e.cause = st ? `MU_CAUSE_ST_MISALIGNED : `MU_CAUSE_LD_MISALIGNED;
        end else if (on_fault_page(a.raw)) begin
            e.valid = 1'b1;
            e.cause = st ? `MU_CAUSE_ST_PAGE_FAULT : `MU_CAUSE_LD_PAGE_FAULT;
        end else if (a.va.hi != {(`MU_XLEN-`MU_VA_BITS){a.va.sign}}) begin
            e.valid = 1'b1;
            e.cause = st ? `MU_CAUSE_ST_ACCESS_FAULT : `MU_CAUSE_LD_ACCESS_FAULT;
        end
        return e;
    endfunction

    function automatic mem_instr_t make_instr(input row_t r);
        mem_instr_t m;
        m = '0;
        m.valid = 1'b1;
        m.op = r.op;
        m.base = r.base;
        m.imm = r.imm;
        m.data = r.data;
        m.rd = r.rd;
        m.gl_index = r.gl;
        if (r.inject) begin
            m.ex.valid = 1'b1;
            m.ex.cause = `MU_CAUSE_LD_ACCESS_FAULT;
            m.ex.origin = r.base + r.imm;
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic value_err(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        err_cnt++;
    endtask

    task automatic other_err(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        other_cnt++;
    endtask

    task automatic compare_req(input dcache_req_t got, input dcache_req_t exp);
        if (got.op !== exp.op) value_err("req_o.op", got.op, exp.op);
        if (got.base !== exp.base) value_err("req_o.base", got.base, exp.base);
        if (got.imm !== exp.imm) value_err("req_o.imm", got.imm, exp.imm);
        if (got.data !== exp.data) value_err("req_o.data", got.data, exp.data);
    endtask

    task automatic compare_xcpt(input string name, input exception_t got, input exception_t exp);
        if (got.valid !== exp.valid) value_err({name, ".valid"}, got.valid, exp.valid);
        if (exp.valid && got.cause !== exp.cause) value_err({name, ".cause"}, got.cause, exp.cause);
        if (exp.valid && got.origin !== exp.origin)
            value_err({name, ".origin"}, got.origin, exp.origin);
    endtask

    task automatic compare_wb(input wb_t got, input wb_t exp);
        if (got.rd !== exp.rd) value_err("wb_o.rd", got.rd, exp.rd);
        if (got.gl_index !== exp.gl_index) value_err("wb_o.gl_index", got.gl_index, exp.gl_index);
        if (got.result !== exp.result) value_err("wb_o.result", got.result, exp.result);
        compare_xcpt("wb_o.ex", got.ex, exp.ex);
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor and dcache model
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (req_o.kill !== kill_i) value_err("req_o.kill", req_o.kill, kill_i);
            if (st_age == 1) begin     // Store in flight, one cycle after accept
                if (!commit_stall_o) other_err("commit_stall_o low while a store is in flight");
                if (mem_gl_index_o !== st_gl) value_err("mem_gl_index_o", mem_gl_index_o, st_gl);
            end
            st_age = (st_age == 1) ? 2 : 0;
            if (req_o.valid) begin
                if (exp_req.size() == 0) begin
                    other_err("request with nothing expected");
                end else begin
                    compare_req(req_o, exp_req.pop_front());
                    st_gl = exp_gl.pop_front();
                end
                if (op_is_store(req_o.op)) begin
                    if (!commit_store_i) other_err("store issued without commit_store_i");
                    if (st_age == 2) other_err("second store issued while one is in flight");
                    st_age = 1;
                end
            end
            if (wb_o.valid) begin
                if (exp_wb.size() == 0) other_err("unexpected writeback");
                else compare_wb(wb_o, exp_wb.pop_front());
            end
            if (xcpt_commit_o.valid) begin
                if (exp_xcpt.size() == 0) other_err("unexpected commit exception");
                else compare_xcpt("xcpt_commit_o", xcpt_commit_o, exp_xcpt.pop_front());
            end
            if (kill_i) begin
                p1 = '0;
                p2 = '0;
                st_age = 0;
            end else begin
                p2 = p1;
                p1 = req_o;
            end
        end
    end

    // Inputs change on the falling edge only
    initial begin
        seed_dummy = $urandom(32'h5b334cf4);
        forever begin
            @(negedge clk_i);
            resp_i = '0;
            if (rstn_i && p2.valid) begin
                resp_i.valid = 1'b1;
                resp_i.addr.raw = p2.base + p2.imm;
                resp_i.data = resp_data(resp_i.addr.raw);
                resp_i.misaligned = is_misaligned(p2.op, resp_i.addr.raw);
                resp_i.page_fault = on_fault_page(resp_i.addr.raw);
            end
            dcache_ready_i = ready_low ? 1'b0 : (($urandom % 4) != 0);
            commit_store_i = ($urandom % 3) != 0;
        end
    end

    always @(posedge clk_i) begin
        cyc++;
        if (cyc >= LIMIT) begin
            $display("Timeout after %0d cycles, the unit did not drain", cyc);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic push_row(input int i);
        exception_t e;
        wb_t        w;
        dcache_req_t q;
        @(negedge clk_i);
        instr_i = make_instr(rows[i]);
        do @(posedge clk_i); while (!in_ready_o);
        q = '0;
        q.valid = 1'b1;
        q.op = rows[i].op;
        q.base = rows[i].base;
        q.imm = rows[i].imm;
        q.data = rows[i].data;
        exp_req.push_back(q);
        exp_gl.push_back(rows[i].gl);
        e = expect_ex(rows[i]);
        if (!op_is_store(rows[i].op)) begin
            w = '0;
            w.valid = 1'b1;
            w.rd = rows[i].rd;
            w.gl_index = rows[i].gl;
            w.result = resp_data(rows[i].base + rows[i].imm);
            w.ex = e;
            exp_wb.push_back(w);
        end else if (e.valid) begin
            exp_xcpt.push_back(e);
        end
        @(negedge clk_i);
        instr_i.valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_req.size() || exp_wb.size() || exp_xcpt.size() || !empty_o)
            @(posedge clk_i);
        repeat (4) @(posedge clk_i);
    endtask

    initial begin
        rstn_i = 1'b0;
        kill_i = 1'b0;
        instr_i = '0;
        commit_store_i = 1'b0;
        dcache_ready_i = 1'b0;
        resp_i = '0;
        ready_low = 1'b0;
        err_cnt = 0;
        other_cnt = 0;
        cyc = 0;
        st_age = 0;
        p1 = '0;
        p2 = '0;
        nc_addr.va.hi = 24'h000001;
        nc_addr.va.sign = 1'b0;
        nc_addr.va.lo = 39'h40;
        //          op   base                    imm  rd  gl  inj data
        rows[0]  = '{LD,  64'h1000,              8,  1,  1,  0, 0};
        rows[1]  = '{LW,  64'h1100,              4,  2,  2,  0, 0};
        rows[2]  = '{SD,  64'h1200,              0,  0,  3,  0, 64'hdead_beef_0123_4567};
        rows[3]  = '{LBU, 64'h1301,              0,  4,  4,  0, 0};
        rows[4]  = '{SW,  64'h1400,              4,  0,  5,  0, 64'h55aa};
        rows[5]  = '{SH,  64'h1500,              2,  0,  6,  0, 64'h1234};
        rows[6]  = '{LW,  64'h3602,              0,  7,  7,  0, 0};
        rows[7]  = '{SD,  64'h3704,              0,  0,  8,  0, 64'h77};
        rows[8]  = '{LD,  64'h3008,              0,  9,  9,  0, 0};
        rows[9]  = '{SW,  64'h3010,              0,  0, 10,  0, 64'h99};
        rows[10] = '{LH,  nc_addr.raw,           0, 11, 11,  0, 0};
        rows[11] = '{LD,  64'h3801,              0, 12, 12,  1, 0};
        rows[12] = '{SB,  64'hffff_fe00_0000_0000, 3, 0, 13, 0, 64'h5};
        rows[13] = '{LHU, 64'hffff_ff80_0000_0010, 0, 14, 14, 0, 0};
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        for (int i = 0; i < N_ROWS; i++) push_row(i);
        drain();

        // Back-pressure fills queue and hold register, then kill
        ready_low = 1'b1;
        pushed = 0;
        for (int k = 0; k < 2 * `MU_LSQ_DEPTH; k++) begin
            @(negedge clk_i);
            instr_i = make_instr(rows[k % N_ROWS]);
            @(posedge clk_i);
            if (!in_ready_o) break;
            pushed++;
        end
        if (pushed != `MU_LSQ_DEPTH + 1) value_err("pushes before in_ready_o low", pushed,
                                                   `MU_LSQ_DEPTH + 1);
        @(negedge clk_i);
        instr_i.valid = 1'b0;
        kill_i = 1'b1;
        @(negedge clk_i);
        kill_i = 1'b0;
        if (!empty_o) other_err("empty_o low after kill");
        ready_low = 1'b0;

        for (int i = 0; i < N_ROWS; i++) push_row(i);
        drain();

        $display("Errors: %0d value, %0d other", err_cnt, other_cnt);
        if (err_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
